//--- Bender.yml
package:
  name: arcade_core_shell

sources:
  - source/rom_load_pkg.sv
  - source/rom_bank.sv
  - source/bridge_word_unpacker.sv
  - source/rom_region_store.sv
  - source/video_formatter.sv
  - source/arcade_core_shell.sv
  - target: simulation
    files:
      - sim/tb_arcade_core_shell.sv

//--- sim/tb_arcade_core_shell.sv
// Arcade core shell testbench
// downloads words into the ROM banks, reads them back through the
// game ports and checks the scaler video against a reference model

`timescale 1ns/100ps
`default_nettype none

module tb_arcade_core_shell import rom_load_pkg::*; ();

    localparam int WRITE_GAP = 24;
    localparam int VIDEO_CYCLES = 3000;

    logic                    clk_74a;
    logic                    reset;
    logic [31:0]             bridge_addr;
    logic                    bridge_wr;
    logic [31:0]             bridge_wr_data;
    logic                    dataslot_requestwrite;
    logic                    dataslot_allcomplete;
    logic                    game_reset;
    logic [MAIN_ROM_AW-1:0]  main_rom_addr;
    logic [SOUND_ROM_AW-1:0] sound_rom_addr;
    logic [WAVE_ROM_AW-1:0]  wave_rom_addr;
    logic [7:0]              main_rom_data;
    logic [7:0]              sound_rom_data;
    logic [7:0]              wave_rom_data;
    logic                    pix_ce;
    core_video_t             core_video;
    scaler_video_t           scaler_video;

    // expected contents of the written bank bytes
    logic [7:0] main_shadow [int];
    logic [7:0] sound_shadow [int];
    logic [7:0] wave_shadow [int];

    logic [MAIN_ROM_AW-1:0]  main_addr_q;
    logic [SOUND_ROM_AW-1:0] sound_addr_q;
    logic [WAVE_ROM_AW-1:0]  wave_addr_q;

    logic [31:0]   lfsr;
    logic          window_open;
    logic          read_check_en;
    logic          checks_on;
    int            errors;
    int            read_checks;
    int            video_checks;

    // reference video state
    logic          hblank_hist [$];
    scaler_video_t exp_video;
    logic          prev_hs;
    logic          prev_vs;

    arcade_core_shell #(
        .MAIN_AW      (MAIN_ROM_AW),
        .SOUND_AW     (SOUND_ROM_AW),
        .WAVE_AW      (WAVE_ROM_AW),
        .HBLANK_DELAY (HBLANK_DELAY)
    ) DUT (
        .clk_74a               (clk_74a),
        .reset                 (reset),
        .bridge_addr           (bridge_addr),
        .bridge_wr             (bridge_wr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .game_reset            (game_reset),
        .main_rom_addr         (main_rom_addr),
        .sound_rom_addr        (sound_rom_addr),
        .wave_rom_addr         (wave_rom_addr),
        .main_rom_data         (main_rom_data),
        .sound_rom_data        (sound_rom_data),
        .wave_rom_data         (wave_rom_data),
        .pix_ce                (pix_ce),
        .core_video            (core_video),
        .scaler_video          (scaler_video)
    );

    always #5 clk_74a = ~clk_74a;

    ////////////////////////////////////////////////////////////
    // random numbers and reference rules

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // bank code in [17:16] and offset below
    // 0 discard, 1 main, 2 sound, 3 wave
    function automatic logic [17:0] region_of(input logic [24:0] a);
        if (a[24:16] != 9'd0) begin
            return 18'd0;
        end
        if (a[15:0] <= 16'h7FFF) begin
            return {2'd1, a[15:0]};
        end
        if (a[15:0] >= 16'hE000 && a[15:0] <= 16'hEFFF) begin
            return {2'd2, a[15:0] - 16'hE000};
        end
        if (a[15:0] >= 16'hFF00) begin
            return {2'd3, a[15:0] - 16'hFF00};
        end
        return 18'd0;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus tasks

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        logic [24:0] a;
        logic [17:0] dec;
        logic [7:0]  b;
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        // big-endian with the msb at the base address
        if (window_open && addr[31:28] == 4'h1) begin
            for (int i = 0; i < 4; i++) begin
                a   = addr[24:0] + 25'(i);
                dec = region_of(a);
                b   = data[31 - 8*i -: 8];
                case (dec[17:16])
                    2'd1: main_shadow[int'(dec[15:0])] = b;
                    2'd2: sound_shadow[int'(dec[15:0])] = b;
                    2'd3: wave_shadow[int'(dec[15:0])] = b;
                    default: ;
                endcase
            end
        end
        repeat (WRITE_GAP) @(posedge clk_74a);
    endtask

    task automatic wait_game_reset(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk_74a);
        while (game_reset !== level && n < limit) begin
            @(negedge clk_74a);
            n++;
        end
        if (game_reset !== level) begin
            errors++;
            $display("timeout: game_reset did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic pulse_slot(input logic open);
        @(posedge clk_74a);
        if (open) begin
            dataslot_requestwrite <= 1'b1;
        end else begin
            dataslot_allcomplete <= 1'b1;
        end
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b0;
        dataslot_allcomplete  <= 1'b0;
        wait_game_reset(open, 3);
        window_open = open;
    endtask

    // reads every bank address once for the compare process
    task automatic sweep_banks();
        @(posedge clk_74a);
        read_check_en <= 1'b1;
        for (int i = 0; i < (1 << MAIN_ROM_AW); i++) begin
            @(posedge clk_74a);
            main_rom_addr  <= i[MAIN_ROM_AW-1:0];
            sound_rom_addr <= i[SOUND_ROM_AW-1:0];
            wave_rom_addr  <= i[WAVE_ROM_AW-1:0];
        end
        repeat (2) @(posedge clk_74a);
        read_check_en <= 1'b0;
    endtask

    task automatic random_main_writes(input int n);
        logic [31:0] a;
        logic [31:0] d;
        for (int i = 0; i < n; i++) begin
            rand_bits(MAIN_ROM_AW - 2, a);
            rand_bits(32, d);
            write_word(32'h1000_0000 | {a[29:0], 2'b00}, d);
        end
    endtask

    task automatic run_video(input int n);
        logic [31:0] v;
        core_video_t cv;
        for (int i = 0; i < n; i++) begin
            @(posedge clk_74a);
            rand_bits(1, v);
            pix_ce <= v[0];
            rand_bits(12, v);
            cv.r = v[11:8];
            cv.g = v[7:4];
            cv.b = v[3:0];
            rand_bits(1, v);
            cv.hblank = v[0];
            // vblank on about one pixel in eight
            rand_bits(3, v);
            cv.vblank = (v[2:0] == 3'd0);
            rand_bits(2, v);
            cv.hs_n = v[1];
            cv.vs_n = v[0];
            core_video <= cv;
        end
        @(posedge clk_74a);
        pix_ce <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // reference video model
    always @(posedge clk_74a) begin
        logic late;
        if (reset) begin
            hblank_hist.delete();
            exp_video = '0;
            prev_hs   = 1'b0;
            prev_vs   = 1'b0;
        end else if (pix_ce) begin
            late = 1'b0;
            if (hblank_hist.size() >= HBLANK_DELAY) begin
                late = hblank_hist.pop_front();
            end
            hblank_hist.push_back(core_video.hblank);
            exp_video.de = !(core_video.vblank || late);
            if (exp_video.de) begin
                exp_video.rgb = {core_video.r, core_video.r, core_video.g,
                                 core_video.g, core_video.b, core_video.b};
            end
            exp_video.hs = prev_hs && !core_video.hs_n;
            exp_video.vs = prev_vs && !core_video.vs_n;
            prev_hs      = core_video.hs_n;
            prev_vs      = core_video.vs_n;
        end
    end

    // read address seen by the bank at each edge
    always @(posedge clk_74a) begin
        main_addr_q  <= main_rom_addr;
        sound_addr_q <= sound_rom_addr;
        wave_addr_q  <= wave_rom_addr;
    end

    ////////////////////////////////////////////////////////////
    // compare process
    always @(negedge clk_74a) begin
        if (checks_on && read_check_en) begin
            if (main_shadow.exists(int'(main_addr_q))) begin
                read_checks++;
                if (main_rom_data !== main_shadow[int'(main_addr_q)]) begin
                    errors++;
                    $display("[ERROR] main_rom_data addr %h got %h expected %h",
                             main_addr_q, main_rom_data, main_shadow[int'(main_addr_q)]);
                end
            end
            if (sound_shadow.exists(int'(sound_addr_q))) begin
                read_checks++;
                if (sound_rom_data !== sound_shadow[int'(sound_addr_q)]) begin
                    errors++;
                    $display("[ERROR] sound_rom_data addr %h got %h expected %h",
                             sound_addr_q, sound_rom_data, sound_shadow[int'(sound_addr_q)]);
                end
            end
            if (wave_shadow.exists(int'(wave_addr_q))) begin
                read_checks++;
                if (wave_rom_data !== wave_shadow[int'(wave_addr_q)]) begin
                    errors++;
                    $display("[ERROR] wave_rom_data addr %h got %h expected %h",
                             wave_addr_q, wave_rom_data, wave_shadow[int'(wave_addr_q)]);
                end
            end
        end
        if (checks_on) begin
            video_checks++;
            if (scaler_video !== exp_video) begin
                errors++;
                $display("[ERROR] scaler_video got %h expected %h", scaler_video, exp_video);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        clk_74a               = 1'b0;
        reset                 = 1'b1;
        bridge_addr           = '0;
        bridge_wr             = 1'b0;
        bridge_wr_data        = '0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        main_rom_addr         = '0;
        sound_rom_addr        = '0;
        wave_rom_addr         = '0;
        pix_ce                = 1'b0;
        core_video            = '0;
        lfsr                  = 32'h4392a45a;
        window_open           = 1'b0;
        read_check_en         = 1'b0;
        checks_on             = 1'b0;
        errors                = 0;
        read_checks           = 0;
        video_checks          = 0;

        repeat (3) @(posedge clk_74a);
        @(negedge clk_74a);
        if (game_reset !== 1'b1) begin
            errors++;
            $display("[ERROR] game_reset under reset got %h expected 1", game_reset);
        end
        repeat (2) @(posedge clk_74a);
        reset     <= 1'b0;
        checks_on <= 1'b1;
        wait_game_reset(1'b0, 3);

        // main ROM download
        pulse_slot(1'b1);
        random_main_writes(40);
        sweep_banks();

        // sound and wave regions and addresses that must be dropped
        for (int i = 0; i < 8; i++) begin
            write_word(32'h1000_E000 + 32'(4*i), 32'hA0B0C0D0 ^ 32'(i * 32'h01030507));
            write_word(32'h1000_FF00 + 32'(4*i), 32'h11223344 ^ 32'(i * 32'h0F0E0D0C));
        end
        write_word(32'h1000_EFFC, 32'hDEADBEEF);
        write_word(32'h1000_FFFC, 32'hCAFEF00D);
        // known main bytes where the dropped writes would alias
        write_word(32'h1000_0000, 32'h01234567);
        write_word(32'h1000_0100, 32'h89ABCDEF);
        write_word(32'h1000_1000, 32'h13579BDF);
        write_word(32'h1000_9000, 32'h5A5A5A5A);
        write_word(32'h1001_0000, 32'hA5A5A5A5);
        write_word(32'h1001_E000, 32'h3C3C3C3C);
        write_word(32'h2000_0100, 32'hC3C3C3C3);
        sweep_banks();

        // writes after all-complete are ignored
        pulse_slot(1'b0);
        write_word(32'h1000_0000, 32'hFEDCBA98);
        write_word(32'h1000_1000, 32'h76543210);
        random_main_writes(10);
        sweep_banks();

        run_video(VIDEO_CYCLES);
        repeat (2) @(posedge clk_74a);

        if (read_checks == 0) begin
            errors++;
            $display("no ROM reads were compared");
        end
        $display("read checks %0d, video checks %0d, errors %0d",
                 read_checks, video_checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/arcade_core_shell.sv
// Arcade core shell
// ROM download from the bridge into the game ROM banks, the
// game reset and the video path to the scaler

`timescale 1ns/100ps
`default_nettype none

module arcade_core_shell import rom_load_pkg::*; #(
    parameter int MAIN_AW      = MAIN_ROM_AW,
    parameter int SOUND_AW     = SOUND_ROM_AW,
    parameter int WAVE_AW      = WAVE_ROM_AW,
    parameter int HBLANK_DELAY = rom_load_pkg::HBLANK_DELAY
) (
    input  wire logic                clk_74a,
    input  wire logic                reset,
    // bridge and data slot
    input  wire logic [31:0]         bridge_addr,
    input  wire logic                bridge_wr,
    input  wire logic [31:0]         bridge_wr_data,
    input  wire logic                dataslot_requestwrite,
    input  wire logic                dataslot_allcomplete,
    // game side
    output logic                     game_reset,
    input  wire logic [MAIN_AW-1:0]  main_rom_addr,
    input  wire logic [SOUND_AW-1:0] sound_rom_addr,
    input  wire logic [WAVE_AW-1:0]  wave_rom_addr,
    output logic [7:0]               main_rom_data,
    output logic [7:0]               sound_rom_data,
    output logic [7:0]               wave_rom_data,
    // video
    input  wire logic                pix_ce,
    input  wire core_video_t         core_video,
    output scaler_video_t            scaler_video
);

    logic      downloading;
    logic      byte_req;
    logic      byte_ack;
    rom_byte_t rom_byte;

    // the game stays in reset for the whole download
    assign game_reset = reset || downloading;

    bridge_word_unpacker unpacker (
        .clk_74a               (clk_74a),
        .reset                 (reset),
        .bridge_addr           (bridge_addr),
        .bridge_wr             (bridge_wr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .downloading           (downloading),
        .byte_req              (byte_req),
        .rom_byte              (rom_byte),
        .byte_ack              (byte_ack)
    );

    rom_region_store #(
        .MAIN_AW  (MAIN_AW),
        .SOUND_AW (SOUND_AW),
        .WAVE_AW  (WAVE_AW)
    ) store (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .byte_req       (byte_req),
        .rom_byte       (rom_byte),
        .byte_ack       (byte_ack),
        .main_rom_addr  (main_rom_addr),
        .sound_rom_addr (sound_rom_addr),
        .wave_rom_addr  (wave_rom_addr),
        .main_rom_data  (main_rom_data),
        .sound_rom_data (sound_rom_data),
        .wave_rom_data  (wave_rom_data)
    );

    video_formatter #(
        .DELAY (HBLANK_DELAY)
    ) formatter (
        .clk_74a      (clk_74a),
        .reset        (reset),
        .pix_ce       (pix_ce),
        .core_video   (core_video),
        .scaler_video (scaler_video)
    );

endmodule

`default_nettype wire

//--- source/bridge_word_unpacker.sv
// Bridge word unpacker
// holds the download window, takes ROM writes from the bridge and
// hands their four bytes, msb first, to the ROM store by req/ack

`timescale 1ns/100ps
`default_nettype none

module bridge_word_unpacker import rom_load_pkg::*; (
    input  wire logic        clk_74a,
    input  wire logic        reset,
    input  wire logic [31:0] bridge_addr,
    input  wire logic        bridge_wr,
    input  wire logic [31:0] bridge_wr_data,
    input  wire logic        dataslot_requestwrite,
    input  wire logic        dataslot_allcomplete,
    output logic             downloading,
    output logic             byte_req,
    output rom_byte_t        rom_byte,
    input  wire logic        byte_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RELEASE
    } unpack_state_t;

    unpack_state_t state;
    logic [1:0]    byte_cnt;
    // bytes not yet offered with the next one on top
    logic [23:0]   rest;
    logic          take_word;

    assign take_word = bridge_wr && downloading && (state == ST_IDLE) &&
                       (bridge_addr[31:28] == LOAD_REGION_NIBBLE);

    // download window
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            downloading <= 1'b0;
        end else if (dataslot_requestwrite) begin
            downloading <= 1'b1;
        end else if (dataslot_allcomplete) begin
            downloading <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // four-phase byte handshake
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            state    <= ST_IDLE;
            byte_req <= 1'b0;
            byte_cnt <= 2'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_word) begin
                        byte_req <= 1'b1;
                        byte_cnt <= 2'd0;
                        state    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (byte_ack) begin
                        byte_req <= 1'b0;
                        state    <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    // wait for the store to drop ack before the next byte
                    if (!byte_ack) begin
                        if (byte_cnt == 2'd3) begin
                            state <= ST_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            byte_req <= 1'b1;
                            state    <= ST_REQ;
                        end
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    byte_req <= 1'b0;
                end
            endcase
        end
    end

    // payload only moves while req is low
    always_ff @(posedge clk_74a) begin
        if (take_word) begin
            rom_byte.addr <= bridge_addr[24:0];
            rom_byte.data <= bridge_wr_data[31:24];
            rest          <= bridge_wr_data[23:0];
        end else if (state == ST_RELEASE && !byte_ack && byte_cnt != 2'd3) begin
            rom_byte.addr <= rom_byte.addr + 25'd1;
            rom_byte.data <= rest[23:16];
            rest          <= {rest[15:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

//--- source/rom_bank.sv
// ROM bank
// byte storage with one write port and one registered read port

`timescale 1ns/100ps
`default_nettype none

module rom_bank #(
    parameter int AW = 8
) (
    input  wire logic          clk_74a,
    input  wire logic          wr_en,
    input  wire logic [AW-1:0] wr_addr,
    input  wire logic [7:0]    wr_data,
    input  wire logic [AW-1:0] rd_addr,
    output logic [7:0]         rd_data
);

    logic [7:0] mem [0:(2**AW)-1];

    // a same-cycle read sees the old byte
    always_ff @(posedge clk_74a) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- source/rom_load_pkg.sv
// ROM download and video types
// shared by the loader, the ROM store and the scaler formatter

`default_nettype none

package rom_load_pkg;

    ////////////////////////////////////////////////////////////
    // download

    // bridge address nibble [31:28] that selects the ROM slot
    localparam logic [3:0] LOAD_REGION_NIBBLE = 4'h1;

    // one byte on its way from the unpacker to the store
    typedef struct packed {
        logic [24:0] addr;
        logic [7:0]  data;
    } rom_byte_t;

    ////////////////////////////////////////////////////////////
    // ROM regions

    localparam int MAIN_ROM_AW  = 15;
    localparam int SOUND_ROM_AW = 12;
    localparam int WAVE_ROM_AW  = 8;

    localparam logic [15:0] SOUND_ROM_BASE = 16'hE000;
    localparam logic [15:0] WAVE_ROM_BASE  = 16'hFF00;

    ////////////////////////////////////////////////////////////
    // video

    // raw video from the game with active-low syncs
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic       hblank;
        logic       vblank;
        logic       hs_n;
        logic       vs_n;
    } core_video_t;

    // scaler side with one-pixel sync pulses
    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } scaler_video_t;

    // hblank lags the pixel data by this many pixel enables
    localparam int HBLANK_DELAY = 9;

endpackage

`default_nettype wire

//--- source/rom_region_store.sv
// ROM region store
// acknowledges downloaded bytes, decodes their region and
// writes them into the main, sound and wave ROM banks

`timescale 1ns/100ps
`default_nettype none

module rom_region_store import rom_load_pkg::*; #(
    parameter int MAIN_AW  = MAIN_ROM_AW,
    parameter int SOUND_AW = SOUND_ROM_AW,
    parameter int WAVE_AW  = WAVE_ROM_AW
) (
    input  wire logic                clk_74a,
    input  wire logic                reset,
    input  wire logic                byte_req,
    input  wire rom_byte_t           rom_byte,
    output logic                     byte_ack,
    input  wire logic [MAIN_AW-1:0]  main_rom_addr,
    input  wire logic [SOUND_AW-1:0] sound_rom_addr,
    input  wire logic [WAVE_AW-1:0]  wave_rom_addr,
    output logic [7:0]               main_rom_data,
    output logic [7:0]               sound_rom_data,
    output logic [7:0]               wave_rom_data
);

    // region ends one past the last byte
    localparam logic [16:0] MAIN_END  = 17'(1) << MAIN_AW;
    localparam logic [16:0] SOUND_END = {1'b0, SOUND_ROM_BASE} + (17'(1) << SOUND_AW);
    localparam logic [16:0] WAVE_END  = {1'b0, WAVE_ROM_BASE} + (17'(1) << WAVE_AW);

    logic        wr_step;
    logic        low_64k;
    logic [16:0] addr_lo;
    logic [15:0] sound_off;
    logic [15:0] wave_off;
    logic        main_we;
    logic        sound_we;
    logic        wave_we;

    ////////////////////////////////////////////////////////////
    // handshake

    // req up with ack not yet raised happens once per byte
    assign wr_step = byte_req && !byte_ack;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            byte_ack <= 1'b0;
        end else if (wr_step) begin
            byte_ack <= 1'b1;
        end else if (!byte_req && byte_ack) begin
            byte_ack <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // region decode
    assign low_64k   = (rom_byte.addr[24:16] == 9'd0);
    assign addr_lo   = {1'b0, rom_byte.addr[15:0]};
    assign sound_off = rom_byte.addr[15:0] - SOUND_ROM_BASE;
    assign wave_off  = rom_byte.addr[15:0] - WAVE_ROM_BASE;

    assign main_we  = wr_step && low_64k && (addr_lo < MAIN_END);
    assign sound_we = wr_step && low_64k && (addr_lo >= {1'b0, SOUND_ROM_BASE}) &&
                      (addr_lo < SOUND_END);
    assign wave_we  = wr_step && low_64k && (addr_lo >= {1'b0, WAVE_ROM_BASE}) &&
                      (addr_lo < WAVE_END);

    ////////////////////////////////////////////////////////////
    // banks
    rom_bank #(
        .AW (MAIN_AW)
    ) main_bank (
        .clk_74a (clk_74a),
        .wr_en   (main_we),
        .wr_addr (rom_byte.addr[MAIN_AW-1:0]),
        .wr_data (rom_byte.data),
        .rd_addr (main_rom_addr),
        .rd_data (main_rom_data)
    );

    rom_bank #(
        .AW (SOUND_AW)
    ) sound_bank (
        .clk_74a (clk_74a),
        .wr_en   (sound_we),
        .wr_addr (sound_off[SOUND_AW-1:0]),
        .wr_data (rom_byte.data),
        .rd_addr (sound_rom_addr),
        .rd_data (sound_rom_data)
    );

    rom_bank #(
        .AW (WAVE_AW)
    ) wave_bank (
        .clk_74a (clk_74a),
        .wr_en   (wave_we),
        .wr_addr (wave_off[WAVE_AW-1:0]),
        .wr_data (rom_byte.data),
        .rd_addr (wave_rom_addr),
        .rd_data (wave_rom_data)
    );

endmodule

`default_nettype wire

//--- source/video_formatter.sv
// Video formatter
// widens the game's 4-bit colour, builds data-enable from a delayed
// hblank and turns the active-low syncs into one-pixel pulses

`timescale 1ns/100ps
`default_nettype none

module video_formatter import rom_load_pkg::*; #(
    parameter int DELAY = HBLANK_DELAY
) (
    input  wire logic        clk_74a,
    input  wire logic        reset,
    input  wire logic        pix_ce,
    input  wire core_video_t core_video,
    output scaler_video_t    scaler_video
);

    // hblank history with the oldest sample on top
    logic [DELAY-1:0] hbl_pipe;
    logic             hbl_late;
    logic             active;
    logic             hs_prev;
    logic             vs_prev;

    assign hbl_late = hbl_pipe[DELAY-1];
    assign active   = !(core_video.vblank || hbl_late);

    ////////////////////////////////////////////////////////////
    // hblank delay
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            hbl_pipe <= '0;
        end else if (pix_ce) begin
            hbl_pipe <= {hbl_pipe[DELAY-2:0], core_video.hblank};
        end
    end

    ////////////////////////////////////////////////////////////
    // scaler outputs
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            scaler_video <= '0;
            hs_prev      <= 1'b0;
            vs_prev      <= 1'b0;
        end else if (pix_ce) begin
            scaler_video.de <= active;
            // colour holds through blanking
            if (active) begin
                scaler_video.rgb <= {{2{core_video.r}}, {2{core_video.g}}, {2{core_video.b}}};
            end
            // pulse on the falling edge of each sync
            scaler_video.hs <= hs_prev && !core_video.hs_n;
            scaler_video.vs <= vs_prev && !core_video.vs_n;
            hs_prev         <= core_video.hs_n;
            vs_prev         <= core_video.vs_n;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
source/rom_load_pkg.sv
source/rom_bank.sv
source/bridge_word_unpacker.sv
source/rom_region_store.sv
source/video_formatter.sv
source/arcade_core_shell.sv
sim/tb_arcade_core_shell.sv
